// ==== logic/core_pkg.sv ====
`default_nettype none

package core_pkg;

	// datapath and register file
	localparam int XLEN = 32;
	localparam int NUM_REGS = 32;
	localparam int REG_AW = 5;
	localparam int IMM_W = 16;

	// back end shape
	localparam int NUM_LANES = 2;
	localparam int WIN_DEPTH = 3;
	localparam int MUL_LATENCY = 3;

	// slot index and occupancy count share one width
	localparam int WIN_W = $clog2(WIN_DEPTH + 1);
	localparam int MUL_CNT_W = $clog2(MUL_LATENCY);

	typedef enum logic [2:0] {
		OP_ADD  = 3'd0,
		OP_SUB  = 3'd1,
		OP_AND  = 3'd2,
		OP_OR   = 3'd3,
		OP_XOR  = 3'd4,
		OP_SLL  = 3'd5,
		OP_ADDI = 3'd6,
		OP_MUL  = 3'd7
	} op_e;

	typedef enum logic {
		LANE_IDLE = 1'b0,
		LANE_MUL  = 1'b1
	} lane_state_e;

endpackage

`default_nettype wire

// ==== logic/issue_window.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue_window (
	input  logic clk,
	input  logic rstn,
	input  logic i_instr_vld,
	input  core_pkg::op_e i_op,
	input  logic [core_pkg::REG_AW-1:0] i_rd,
	input  logic [core_pkg::REG_AW-1:0] i_rs,
	input  logic [core_pkg::REG_AW-1:0] i_rt,
	input  logic [core_pkg::IMM_W-1:0] i_imm,
	input  logic [core_pkg::NUM_LANES-1:0] i_lane_busy,
	input  logic [core_pkg::NUM_LANES-1:0][core_pkg::XLEN-1:0] i_rs_val,
	input  logic [core_pkg::NUM_LANES-1:0][core_pkg::XLEN-1:0] i_rt_val,
	input  logic [core_pkg::NUM_LANES-1:0] i_rel_vld,
	input  logic [core_pkg::NUM_LANES-1:0][core_pkg::REG_AW-1:0] i_rel_addr,
	output logic o_instr_rdy,
	output logic [core_pkg::NUM_LANES-1:0][core_pkg::REG_AW-1:0] o_rs_addr,
	output logic [core_pkg::NUM_LANES-1:0][core_pkg::REG_AW-1:0] o_rt_addr,
	output logic [core_pkg::NUM_LANES-1:0] o_iss_vld,
	output core_pkg::op_e [core_pkg::NUM_LANES-1:0] o_iss_op,
	output logic [core_pkg::NUM_LANES-1:0][core_pkg::REG_AW-1:0] o_iss_rd,
	output logic [core_pkg::NUM_LANES-1:0][core_pkg::XLEN-1:0] o_iss_rs_val,
	output logic [core_pkg::NUM_LANES-1:0][core_pkg::XLEN-1:0] o_iss_rt_val,
	output logic [core_pkg::NUM_LANES-1:0][core_pkg::IMM_W-1:0] o_iss_imm
);
	import core_pkg::*;

	// slot 0 is the oldest entry
	logic [WIN_DEPTH-1:0] slot_vld;
	op_e slot_op [WIN_DEPTH];
	logic [REG_AW-1:0] slot_rd [WIN_DEPTH];
	logic [REG_AW-1:0] slot_rs [WIN_DEPTH];
	logic [REG_AW-1:0] slot_rt [WIN_DEPTH];
	logic [IMM_W-1:0] slot_imm [WIN_DEPTH];

	logic [WIN_DEPTH-1:0] nxt_vld;
	op_e nxt_op [WIN_DEPTH];
	logic [REG_AW-1:0] nxt_rd [WIN_DEPTH];
	logic [REG_AW-1:0] nxt_rs [WIN_DEPTH];
	logic [REG_AW-1:0] nxt_rt [WIN_DEPTH];
	logic [IMM_W-1:0] nxt_imm [WIN_DEPTH];
	logic [WIN_W-1:0] keep_cnt;

	logic [NUM_REGS-1:0] sb;
	logic [NUM_REGS-1:0] rel_mask;
	logic [NUM_REGS-1:0] pending;
	logic [NUM_REGS-1:0] set_mask;

	logic [WIN_DEPTH-1:0] slot_rdy;
	logic [WIN_DEPTH-1:0] slot_iss;
	logic [NUM_LANES-1:0] lane_go;
	logic [WIN_W-1:0] lane_slot [NUM_LANES];

	function automatic logic reg_hit(input logic [REG_AW-1:0] a, input logic [REG_AW-1:0] b);
		return (a != '0) && (a == b);
	endfunction

	// writeback releases free their register this cycle to match the forwarding path
	always_comb begin
		rel_mask = '0;
		for (int l = 0; l < NUM_LANES; l++) begin
			if (i_rel_vld[l]) begin
				rel_mask[i_rel_addr[l]] = 1'b1;
			end
		end
	end

	assign pending = sb & ~rel_mask;

	always_comb begin
		for (int s = 0; s < WIN_DEPTH; s++) begin
			slot_rdy[s] = slot_vld[s] && !pending[slot_rs[s]] && !pending[slot_rt[s]] &&
				!pending[slot_rd[s]];
			// an older waiting entry blocks raw, war and waw
			for (int o = 0; o < s; o++) begin
				if (slot_vld[o] && (reg_hit(slot_rd[o], slot_rs[s]) ||
						reg_hit(slot_rd[o], slot_rt[s]) || reg_hit(slot_rs[o], slot_rd[s]) ||
						reg_hit(slot_rt[o], slot_rd[s]) || reg_hit(slot_rd[o], slot_rd[s]))) begin
					slot_rdy[s] = 1'b0;
				end
			end
		end
	end

	// oldest ready entry takes the lowest free lane
	always_comb begin
		logic [NUM_LANES-1:0] taken;
		logic placed;
		taken = i_lane_busy;
		lane_go = '0;
		slot_iss = '0;
		for (int l = 0; l < NUM_LANES; l++) begin
			lane_slot[l] = '0;
		end
		for (int s = 0; s < WIN_DEPTH; s++) begin
			placed = 1'b0;
			for (int l = 0; l < NUM_LANES; l++) begin
				if (slot_rdy[s] && !placed && !taken[l]) begin
					taken[l] = 1'b1;
					lane_go[l] = 1'b1;
					lane_slot[l] = WIN_W'(s);
					slot_iss[s] = 1'b1;
					placed = 1'b1;
				end
			end
		end
	end

	always_comb begin
		set_mask = '0;
		for (int l = 0; l < NUM_LANES; l++) begin
			if (lane_go[l]) begin
				set_mask[slot_rd[lane_slot[l]]] = 1'b1;
			end
		end
		set_mask[0] = 1'b0;
	end

	always_comb begin
		for (int l = 0; l < NUM_LANES; l++) begin
			o_rs_addr[l] = slot_rs[lane_slot[l]];
			o_rt_addr[l] = slot_rt[lane_slot[l]];
		end
	end

	// compact survivors toward slot 0 and put the new instruction in the first free slot
	always_comb begin
		int n;
		n = 0;
		nxt_vld = '0;
		for (int s = 0; s < WIN_DEPTH; s++) begin
			nxt_op[s] = slot_op[s];
			nxt_rd[s] = slot_rd[s];
			nxt_rs[s] = slot_rs[s];
			nxt_rt[s] = slot_rt[s];
			nxt_imm[s] = slot_imm[s];
		end
		for (int s = 0; s < WIN_DEPTH; s++) begin
			if (slot_vld[s] && !slot_iss[s]) begin
				nxt_vld[n] = 1'b1;
				nxt_op[n] = slot_op[s];
				nxt_rd[n] = slot_rd[s];
				nxt_rs[n] = slot_rs[s];
				nxt_rt[n] = slot_rt[s];
				nxt_imm[n] = slot_imm[s];
				n++;
			end
		end
		keep_cnt = WIN_W'(n);
		if (i_instr_vld && n < WIN_DEPTH) begin
			nxt_vld[n] = 1'b1;
			nxt_op[n] = i_op;
			nxt_rd[n] = i_rd;
			nxt_rs[n] = i_rs;
			// addi has no rt, so it carries no false dependency
			nxt_rt[n] = (i_op == OP_ADDI) ? '0 : i_rt;
			nxt_imm[n] = i_imm;
		end
	end

	assign o_instr_rdy = keep_cnt < WIN_W'(WIN_DEPTH);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			slot_vld <= '0;
			sb <= '0;
			o_iss_vld <= '0;
		end else begin
			slot_vld <= nxt_vld;
			sb <= pending | set_mask;
			o_iss_vld <= lane_go;
		end
	end

	always_ff @(posedge clk) begin
		for (int s = 0; s < WIN_DEPTH; s++) begin
			slot_op[s] <= nxt_op[s];
			slot_rd[s] <= nxt_rd[s];
			slot_rs[s] <= nxt_rs[s];
			slot_rt[s] <= nxt_rt[s];
			slot_imm[s] <= nxt_imm[s];
		end
		for (int l = 0; l < NUM_LANES; l++) begin
			if (lane_go[l]) begin
				o_iss_op[l] <= slot_op[lane_slot[l]];
				o_iss_rd[l] <= slot_rd[lane_slot[l]];
				o_iss_rs_val[l] <= i_rs_val[l];
				o_iss_rt_val[l] <= i_rt_val[l];
				o_iss_imm[l] <= slot_imm[lane_slot[l]];
			end
		end
	end

	generate
		for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane_chk
			// no strobe while the lane still counts a multiply
			for (genvar k = 1; k < MUL_LATENCY; k++) begin : g_mul_gap
				a_idle_lane: assert property (@(posedge clk) disable iff (!rstn)
					o_iss_vld[l] |-> !$past(o_iss_vld[l] && o_iss_op[l] == OP_MUL, k));
			end
			a_rel_pending: assert property (@(posedge clk) disable iff (!rstn)
				i_rel_vld[l] |-> sb[i_rel_addr[l]]);
			for (genvar m = l + 1; m < NUM_LANES; m++) begin : g_pair
				a_one_slot: assert property (@(posedge clk) disable iff (!rstn)
					!(lane_go[l] && lane_go[m] && lane_slot[l] == lane_slot[m]));
			end
		end
	endgenerate

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module reg_file (
	input  logic clk,
	input  logic rstn,
	input  logic [core_pkg::NUM_LANES-1:0][core_pkg::REG_AW-1:0] i_rs_addr,
	input  logic [core_pkg::NUM_LANES-1:0][core_pkg::REG_AW-1:0] i_rt_addr,
	input  logic [core_pkg::NUM_LANES-1:0] i_we,
	input  logic [core_pkg::NUM_LANES-1:0][core_pkg::REG_AW-1:0] i_waddr,
	input  logic [core_pkg::NUM_LANES-1:0][core_pkg::XLEN-1:0] i_wdata,
	output logic [core_pkg::NUM_LANES-1:0][core_pkg::XLEN-1:0] o_rs_val,
	output logic [core_pkg::NUM_LANES-1:0][core_pkg::XLEN-1:0] o_rt_val
);
	import core_pkg::*;

	logic [XLEN-1:0] regs [NUM_REGS];

	// bypass from writeback, later lane wins
	function automatic logic [XLEN-1:0] read_port(input logic [REG_AW-1:0] addr);
		logic [XLEN-1:0] val;
		val = regs[addr];
		for (int l = 0; l < NUM_LANES; l++) begin
			if (i_we[l] && i_waddr[l] == addr) begin
				val = i_wdata[l];
			end
		end
		if (addr == '0) begin
			val = '0;
		end
		return val;
	endfunction

	always_comb begin
		for (int l = 0; l < NUM_LANES; l++) begin
			o_rs_val[l] = read_port(i_rs_addr[l]);
			o_rt_val[l] = read_port(i_rt_addr[l]);
		end
	end

	// architectural state starts from all zero
	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int r = 0; r < NUM_REGS; r++) begin
				regs[r] <= '0;
			end
		end else begin
			for (int l = 0; l < NUM_LANES; l++) begin
				if (i_we[l]) begin
					regs[i_waddr[l]] <= i_wdata[l];
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/exec_lane.sv ====
`timescale 1ns/10ps
`default_nettype none

module exec_lane (
	input  logic clk,
	input  logic rstn,
	input  logic i_iss_vld,
	input  core_pkg::op_e i_op,
	input  logic [core_pkg::REG_AW-1:0] i_rd,
	input  logic [core_pkg::XLEN-1:0] i_rs_val,
	input  logic [core_pkg::XLEN-1:0] i_rt_val,
	input  logic [core_pkg::IMM_W-1:0] i_imm,
	output logic o_busy,
	output logic o_res_vld,
	output logic [core_pkg::REG_AW-1:0] o_res_rd,
	output logic [core_pkg::XLEN-1:0] o_res_val
);
	import core_pkg::*;

	lane_state_e state;
	logic [MUL_CNT_W-1:0] mul_cnt;
	logic mul_done;
	logic [XLEN-1:0] mul_a;
	logic [XLEN-1:0] mul_b;
	logic [XLEN-1:0] mul_lo;
	logic [XLEN-1:0] imm_ext;
	logic [XLEN-1:0] alu_val;

	assign imm_ext = {{(XLEN - IMM_W){i_imm[IMM_W-1]}}, i_imm};

	always_comb begin
		case (i_op)
			OP_ADD: alu_val = i_rs_val + i_rt_val;
			OP_SUB: alu_val = i_rs_val - i_rt_val;
			OP_AND: alu_val = i_rs_val & i_rt_val;
			OP_OR: alu_val = i_rs_val | i_rt_val;
			OP_XOR: alu_val = i_rs_val ^ i_rt_val;
			OP_SLL: alu_val = i_rs_val << i_rt_val[4:0];
			OP_ADDI: alu_val = i_rs_val + imm_ext;
			default: alu_val = '0;
		endcase
	end

	// low half of the product only
	assign mul_lo = mul_a * mul_b;
	assign mul_done = (state == LANE_MUL) && (mul_cnt == MUL_CNT_W'(MUL_LATENCY - 2));

	// busy already in the cycle the multiply strobe is on the wire
	assign o_busy = (state == LANE_MUL) || (i_iss_vld && i_op == OP_MUL);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= LANE_IDLE;
			mul_cnt <= '0;
			o_res_vld <= 1'b0;
		end else begin
			o_res_vld <= 1'b0;
			case (state)
				LANE_IDLE: begin
					if (i_iss_vld && i_op == OP_MUL) begin
						state <= LANE_MUL;
						mul_cnt <= '0;
					end else if (i_iss_vld) begin
						o_res_vld <= 1'b1;
					end
				end
				LANE_MUL: begin
					if (mul_done) begin
						state <= LANE_IDLE;
						o_res_vld <= 1'b1;
					end else begin
						mul_cnt <= mul_cnt + 1'b1;
					end
				end
				default: state <= LANE_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (i_iss_vld) begin
			o_res_rd <= i_rd;
			mul_a <= i_rs_val;
			mul_b <= i_rt_val;
		end
		if (state == LANE_IDLE && i_iss_vld) begin
			o_res_val <= alu_val;
		end else if (mul_done) begin
			o_res_val <= mul_lo;
		end
	end

	a_no_issue_in_mul: assert property (@(posedge clk) disable iff (!rstn)
		state == LANE_MUL |-> !i_iss_vld);

endmodule

`default_nettype wire

// ==== logic/writeback_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module writeback_stage (
	input  logic clk,
	input  logic rstn,
	input  logic [core_pkg::NUM_LANES-1:0] i_res_vld,
	input  logic [core_pkg::NUM_LANES-1:0][core_pkg::REG_AW-1:0] i_res_rd,
	input  logic [core_pkg::NUM_LANES-1:0][core_pkg::XLEN-1:0] i_res_val,
	output logic [core_pkg::NUM_LANES-1:0] o_we,
	output logic [core_pkg::NUM_LANES-1:0][core_pkg::REG_AW-1:0] o_waddr,
	output logic [core_pkg::NUM_LANES-1:0][core_pkg::XLEN-1:0] o_wdata,
	output logic [core_pkg::NUM_LANES-1:0] o_wb_vld,
	output logic [core_pkg::NUM_LANES-1:0][core_pkg::REG_AW-1:0] o_wb_addr,
	output logic [core_pkg::NUM_LANES-1:0][core_pkg::XLEN-1:0] o_wb_data
);
	import core_pkg::*;

	logic [NUM_LANES-1:0] wb_vld;
	logic [NUM_LANES-1:0][REG_AW-1:0] wb_addr;
	logic [NUM_LANES-1:0][XLEN-1:0] wb_data;

	// results for register 0 vanish here
	always_ff @(posedge clk) begin
		if (!rstn) begin
			wb_vld <= '0;
		end else begin
			for (int l = 0; l < NUM_LANES; l++) begin
				wb_vld[l] <= i_res_vld[l] && (i_res_rd[l] != '0);
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int l = 0; l < NUM_LANES; l++) begin
			if (i_res_vld[l]) begin
				wb_addr[l] <= i_res_rd[l];
				wb_data[l] <= i_res_val[l];
			end
		end
	end

	// one registered result feeds regfile, scoreboard release and outputs
	assign o_we = wb_vld;
	assign o_waddr = wb_addr;
	assign o_wdata = wb_data;
	assign o_wb_vld = wb_vld;
	assign o_wb_addr = wb_addr;
	assign o_wb_data = wb_data;

	generate
		for (genvar a = 0; a < NUM_LANES; a++) begin : g_wr
			for (genvar b = a + 1; b < NUM_LANES; b++) begin : g_pair
				a_distinct_rd: assert property (@(posedge clk) disable iff (!rstn)
					!(wb_vld[a] && wb_vld[b] && wb_addr[a] == wb_addr[b]));
			end
		end
	endgenerate

endmodule

`default_nettype wire

// ==== logic/ooo_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module ooo_core (
	input  logic clk,
	input  logic rstn,
	input  logic i_instr_vld,
	input  core_pkg::op_e i_op,
	input  logic [core_pkg::REG_AW-1:0] i_rd,
	input  logic [core_pkg::REG_AW-1:0] i_rs,
	input  logic [core_pkg::REG_AW-1:0] i_rt,
	input  logic [core_pkg::IMM_W-1:0] i_imm,
	output logic o_instr_rdy,
	output logic [core_pkg::NUM_LANES-1:0] o_wb_vld,
	output logic [core_pkg::NUM_LANES-1:0][core_pkg::REG_AW-1:0] o_wb_addr,
	output logic [core_pkg::NUM_LANES-1:0][core_pkg::XLEN-1:0] o_wb_data
);
	import core_pkg::*;

	logic [NUM_LANES-1:0][REG_AW-1:0] rs_addr;
	logic [NUM_LANES-1:0][REG_AW-1:0] rt_addr;
	logic [NUM_LANES-1:0][XLEN-1:0] rs_val;
	logic [NUM_LANES-1:0][XLEN-1:0] rt_val;

	logic [NUM_LANES-1:0] lane_busy;
	logic [NUM_LANES-1:0] iss_vld;
	op_e [NUM_LANES-1:0] iss_op;
	logic [NUM_LANES-1:0][REG_AW-1:0] iss_rd;
	logic [NUM_LANES-1:0][XLEN-1:0] iss_rs_val;
	logic [NUM_LANES-1:0][XLEN-1:0] iss_rt_val;
	logic [NUM_LANES-1:0][IMM_W-1:0] iss_imm;

	logic [NUM_LANES-1:0] res_vld;
	logic [NUM_LANES-1:0][REG_AW-1:0] res_rd;
	logic [NUM_LANES-1:0][XLEN-1:0] res_val;

	logic [NUM_LANES-1:0] we;
	logic [NUM_LANES-1:0][REG_AW-1:0] waddr;
	logic [NUM_LANES-1:0][XLEN-1:0] wdata;

	issue_window u_window (
		.clk(clk),
		.rstn(rstn),
		.i_instr_vld(i_instr_vld),
		.i_op(i_op),
		.i_rd(i_rd),
		.i_rs(i_rs),
		.i_rt(i_rt),
		.i_imm(i_imm),
		.i_lane_busy(lane_busy),
		.i_rs_val(rs_val),
		.i_rt_val(rt_val),
		.i_rel_vld(we),
		.i_rel_addr(waddr),
		.o_instr_rdy(o_instr_rdy),
		.o_rs_addr(rs_addr),
		.o_rt_addr(rt_addr),
		.o_iss_vld(iss_vld),
		.o_iss_op(iss_op),
		.o_iss_rd(iss_rd),
		.o_iss_rs_val(iss_rs_val),
		.o_iss_rt_val(iss_rt_val),
		.o_iss_imm(iss_imm)
	);

	reg_file u_regs (
		.clk(clk),
		.rstn(rstn),
		.i_rs_addr(rs_addr),
		.i_rt_addr(rt_addr),
		.i_we(we),
		.i_waddr(waddr),
		.i_wdata(wdata),
		.o_rs_val(rs_val),
		.o_rt_val(rt_val)
	);

	generate
		for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
			exec_lane u_lane (
				.clk(clk),
				.rstn(rstn),
				.i_iss_vld(iss_vld[g]),
				.i_op(iss_op[g]),
				.i_rd(iss_rd[g]),
				.i_rs_val(iss_rs_val[g]),
				.i_rt_val(iss_rt_val[g]),
				.i_imm(iss_imm[g]),
				.o_busy(lane_busy[g]),
				.o_res_vld(res_vld[g]),
				.o_res_rd(res_rd[g]),
				.o_res_val(res_val[g])
			);
		end
	endgenerate

	writeback_stage u_wb (
		.clk(clk),
		.rstn(rstn),
		.i_res_vld(res_vld),
		.i_res_rd(res_rd),
		.i_res_val(res_val),
		.o_we(we),
		.o_waddr(waddr),
		.o_wdata(wdata),
		.o_wb_vld(o_wb_vld),
		.o_wb_addr(o_wb_addr),
		.o_wb_data(o_wb_data)
	);

endmodule

`default_nettype wire

// ==== tb/tb_ooo_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_ooo_core;
	import core_pkg::*;

	localparam int MAX_INSTR = 64;
	localparam int FIELDS = 6;
	localparam int RDY_LIMIT = 200;
	localparam int DRAIN_LIMIT = 400;
	localparam int SETTLE_CYCLES = 8;
	localparam logic [31:0] LFSR_SEED = 32'h2caf_597c;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	logic clk;
	logic rstn;
	logic i_instr_vld;
	op_e i_op;
	logic [REG_AW-1:0] i_rd;
	logic [REG_AW-1:0] i_rs;
	logic [REG_AW-1:0] i_rt;
	logic [IMM_W-1:0] i_imm;
	logic o_instr_rdy;
	logic [NUM_LANES-1:0] o_wb_vld;
	logic [NUM_LANES-1:0][REG_AW-1:0] o_wb_addr;
	logic [NUM_LANES-1:0][XLEN-1:0] o_wb_data;

	// six words per instruction: op rd rs rt imm expected
	logic [31:0] prog_mem [MAX_INSTR * FIELDS];
	int num_instr;
	int exp_wb_cnt;
	int wb_cnt;
	int err_cnt;
	int tests_run;
	int tests_failed;
	logic timed_out;
	logic saw_full;
	logic [31:0] lfsr_state;

	// results still owed, in program order
	int pend_addr[$];
	int pend_line[$];
	logic [31:0] pend_val[$];

	ooo_core uut (
		.clk(clk),
		.rstn(rstn),
		.i_instr_vld(i_instr_vld),
		.i_op(i_op),
		.i_rd(i_rd),
		.i_rs(i_rs),
		.i_rt(i_rt),
		.i_imm(i_imm),
		.o_instr_rdy(o_instr_rdy),
		.o_wb_vld(o_wb_vld),
		.o_wb_addr(o_wb_addr),
		.o_wb_data(o_wb_data)
	);

	always #2 clk = ~clk;

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s got %08h expected %08h", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ LFSR_TAPS;
		end
		return s >> 1;
	endfunction

	task automatic draw_gap(output int gap);
		gap = 0;
		for (int b = 0; b < 2; b++) begin
			gap = (gap << 1) | int'(lfsr_state[0]);
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic report_test(input string name, input int errs_before, input logic aborted);
		tests_run++;
		if (err_cnt != errs_before || aborted) begin
			tests_failed++;
			$display("test %0d %s: fail", tests_run, name);
		end else begin
			$display("test %0d %s: ok", tests_run, name);
		end
	endtask

	// pulses are registered at the rising edge, so the falling edge sees them settled
	always @(negedge clk) begin : wb_monitor
		int hit;
		if (rstn) begin
			for (int l = 0; l < NUM_LANES; l++) begin
				if (o_wb_vld[l] === 1'b1) begin
					wb_cnt++;
					check_value("write-back to register 0", 32'(o_wb_addr[l] == '0), 32'd0);
					hit = -1;
					for (int i = 0; i < pend_addr.size(); i++) begin
						if (hit < 0 && pend_addr[i] == int'(o_wb_addr[l])) begin
							hit = i;
						end
					end
					if (hit < 0) begin
						check_value($sformatf("unexpected write to r%0d", o_wb_addr[l]), 32'd1,
							32'd0);
					end else begin
						check_value($sformatf("instr %0d r%0d", pend_line[hit], o_wb_addr[l]),
							o_wb_data[l], pend_val[hit]);
						pend_addr.delete(hit);
						pend_line.delete(hit);
						pend_val.delete(hit);
					end
				end
			end
		end
	end

	task automatic send_instr(input int idx);
		int base;
		int waited;
		base = idx * FIELDS;
		i_op = op_e'(prog_mem[base][2:0]);
		i_rd = prog_mem[base + 1][REG_AW-1:0];
		i_rs = prog_mem[base + 2][REG_AW-1:0];
		i_rt = prog_mem[base + 3][REG_AW-1:0];
		i_imm = prog_mem[base + 4][IMM_W-1:0];
		i_instr_vld = 1'b1;
		if (i_rd != '0) begin
			pend_addr.push_back(int'(i_rd));
			pend_line.push_back(idx);
			pend_val.push_back(prog_mem[base + 5]);
		end
		waited = 0;
		while (o_instr_rdy !== 1'b1 && waited < RDY_LIMIT) begin
			saw_full = 1'b1;
			@(negedge clk);
			waited++;
		end
		if (o_instr_rdy !== 1'b1) begin
			$display("timeout: core never accepted instr %0d", idx);
			timed_out = 1'b1;
		end
		@(negedge clk);
		i_instr_vld = 1'b0;
	endtask

	initial begin
		int errs;
		int waited;
		int gap;
		clk = 1'b0;
		rstn = 1'b0;
		i_instr_vld = 1'b0;
		i_op = OP_ADD;
		i_rd = '0;
		i_rs = '0;
		i_rt = '0;
		i_imm = '0;
		err_cnt = 0;
		wb_cnt = 0;
		tests_run = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		saw_full = 1'b0;
		lfsr_state = LFSR_SEED;

		$readmemh("tb/program_input.txt", prog_mem);
		num_instr = 0;
		exp_wb_cnt = 0;
		while (num_instr < MAX_INSTR && !$isunknown(prog_mem[num_instr * FIELDS])) begin
			if (prog_mem[num_instr * FIELDS + 1][REG_AW-1:0] != '0) begin
				exp_wb_cnt++;
			end
			num_instr++;
		end
		$display("loaded %0d instructions", num_instr);

		// reset: no write-back while held, ready comes up after release
		errs = err_cnt;
		for (int c = 0; c < 2; c++) begin
			@(negedge clk);
			check_value("o_wb_vld in reset", 32'(o_wb_vld), 32'd0);
		end
		rstn = 1'b1;
		waited = 0;
		while (o_instr_rdy !== 1'b1 && waited < RDY_LIMIT) begin
			check_value("o_wb_vld after reset", 32'(o_wb_vld), 32'd0);
			@(negedge clk);
			waited++;
		end
		if (o_instr_rdy !== 1'b1) begin
			$display("timeout: o_instr_rdy never rose after reset");
			timed_out = 1'b1;
		end
		check_value("o_wb_vld after reset", 32'(o_wb_vld), 32'd0);
		report_test("reset", errs, timed_out);

		errs = err_cnt;
		for (int n = 0; n < num_instr && !timed_out; n++) begin
			send_instr(n);
			draw_gap(gap);
			for (int g = 0; g < gap; g++) begin
				@(negedge clk);
			end
		end
		report_test("program stream", errs, timed_out);

		errs = err_cnt;
		check_value("window full seen", 32'(saw_full), 32'd1);
		report_test("full window", errs, 1'b0);

		errs = err_cnt;
		waited = 0;
		while (pend_addr.size() != 0 && waited < DRAIN_LIMIT && !timed_out) begin
			@(negedge clk);
			waited++;
		end
		if (pend_addr.size() != 0) begin
			$display("timeout: %0d results never came back", pend_addr.size());
			timed_out = 1'b1;
		end
		// stray pulses would show up here
		for (int c = 0; c < SETTLE_CYCLES; c++) begin
			@(negedge clk);
		end
		check_value("write-back pulse count", 32'(wb_cnt), 32'(exp_wb_cnt));
		check_value("results left over", 32'(pend_addr.size()), 32'd0);
		report_test("drain and count", errs, timed_out);

		$display("tests %0d, failed %0d, check errors %0d", tests_run, tests_failed, err_cnt);
		if (err_cnt == 0 && !timed_out) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/program_input.txt ====
// op rd rs rt imm expected, all hex; op 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 addi 7 mul
// expected is the sequential result from all-zero registers; rd 0 lines write nothing
6 01 00 00 0064 00000064
6 02 00 00 fff6 fffffff6
6 03 00 00 0f0f 00000f0f
6 04 00 07 0005 00000005
0 05 01 02 0000 0000005a
1 06 01 03 0000 fffff155
2 07 02 03 0000 00000f06
3 08 01 03 0000 00000f6f
4 09 03 02 0000 fffff0f9
5 0a 01 04 0000 00000c80
0 0b 0a 01 0000 00000ce4
1 0b 0b 04 0000 00000cdf
4 0c 0b 05 0000 00000c85
6 01 0c 00 ff00 00000b85
5 0d 01 04 0000 000170a0
7 0e 01 04 0000 00003999
6 0f 00 00 0003 00000003
7 11 03 0f 0000 00002d2d
0 11 0f 0f 0000 00000006
0 00 01 04 0000 00000000
6 13 00 00 0007 00000007
3 14 00 03 0000 00000f0f
7 15 0f 0f 0000 00000009
7 15 15 0f 0000 0000001b
7 15 15 0f 0000 00000051
7 15 15 0f 0000 000000f3
7 15 15 0f 0000 000002d9
7 15 15 0f 0000 0000088b
7 15 15 0f 0000 000019a1
0 17 15 0e 0000 0000533a
1 18 00 15 0000 ffffe65f

// ==== files.f ====
logic/core_pkg.sv
logic/issue_window.sv
logic/reg_file.sv
logic/exec_lane.sv
logic/writeback_stage.sv
logic/ooo_core.sv
tb/tb_ooo_core.sv

// ==== Bender.yml ====
package:
  name: ooo_core

sources:
  - logic/core_pkg.sv
  - logic/issue_window.sv
  - logic/reg_file.sv
  - logic/exec_lane.sv
  - logic/writeback_stage.sv
  - logic/ooo_core.sv
  - target: test
    files:
      - tb/tb_ooo_core.sv
